/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/alu.sv
      - hw/reg_file.sv
      - hw/datapath.sv
      - hw/control_fsm.sv
      - hw/cpu_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_memory.sv
      - tests/tb_cpu_core.sv

/* compile.f */
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/datapath.sv
hw/control_fsm.sv
hw/cpu_core.sv
tests/tb_memory.sv
tests/tb_cpu_core.sv

/* hw/alu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
    input  logic [`CPU_WORD_WIDTH-1:0] a,
    input  logic [`CPU_WORD_WIDTH-1:0] b,
    input  logic                       cin,
    input  ctrl_pkg::alu_op_e          op,
    output logic [`CPU_WORD_WIDTH-1:0] result,
    output ctrl_pkg::flags_t           flags
);
    import ctrl_pkg::*;

    localparam int W = `CPU_WORD_WIDTH;

    logic [W-1:0] minu;     // minuend
    logic [W-1:0] subt;     // subtrahend
    logic [W:0]   sum;      // carry out in the top bit
    logic [W:0]   diff;     // borrow in the top bit

    assign minu = (op == ALU_NEG_SBB) ? b : a;   // neg swaps roles
    assign subt = (op == ALU_NEG_SBB) ? a : b;
    assign sum  = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
    assign diff = {1'b0, minu} - {1'b0, subt} - {{W{1'b0}}, cin};

    always_comb begin
        result = '0;
        flags  = '0;
        case (op)
            ALU_ADC: begin
                result         = sum[W-1:0];
                flags.carry    = sum[W];
                flags.overflow = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
            end
            ALU_SBB, ALU_NEG_SBB: begin
                result         = diff[W-1:0];
                flags.carry    = diff[W];
                flags.overflow = (minu[W-1] != subt[W-1]) && (diff[W-1] != minu[W-1]);
            end
            ALU_NOT: result = ~a;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;                // also the pass path with one side gated
            ALU_XOR: result = a ^ b;
            ALU_SHL: begin
                result      = {a[W-2:0], 1'b0};
                flags.carry = a[W-1];               // bit shifted out
            end
            ALU_SHR: begin
                result      = {1'b0, a[W-1:1]};
                flags.carry = a[0];
            end
            ALU_SAR: begin
                result      = {a[W-1], a[W-1:1]};   // sign kept
                flags.carry = a[0];
            end
            default: ;
        endcase
        flags.zero = (result == '0);
        flags.sign = result[W-1];
    end

endmodule

/* hw/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::instr_t    instr,
    input  ctrl_pkg::flags_t   flags,
    output ctrl_pkg::bus_src_e bus_src,
    output logic               t1_we,
    output logic               t2_we,
    output logic               t1_oe,
    output logic               t2_oe,
    output logic               am_we,
    output logic               ri_we,
    output logic               ind_we,
    output logic               cp_inc,
    output logic               fetch_addr,
    output logic               mem_rd,
    output logic               mem_wr,
    output isa_pkg::reg_idx_e  reg_addr,
    output logic               reg_we,
    output ctrl_pkg::alu_op_e  alu_op,
    output logic               alu_cin
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [4:0] {
        S_RESET, S_FETCH, S_FETCH_LD, S_DECODE,
        S_ADDR_SUM_BASE, S_ADDR_SUM_IDX, S_ADDR_SUM_ADD, S_ADDR_REG,
        S_LD_SRC_REG, S_LD_SRC_AM, S_LD_SRC_RD, S_LD_SRC_CAP,
        S_LD_DST_REG, S_LD_DST_AM, S_LD_DST_RD, S_LD_DST_CAP,
        S_EXEC_1OP, S_EXEC_2OP, S_STORE_REG, S_STORE_MEM, S_INC_CP
    } state_e;

    state_e   state;
    state_e   state_next;
    state_e   dec_src;          // continuation after address calc
    state_e   dec_src_next;
    state_e   dec_dst;          // continuation after source load
    state_e   dec_dst_next;
    state_e   dec_store;        // continuation after execute
    state_e   dec_store_next;
    state_e   exec_state;
    logic     dec_d;
    logic     dec_d_next;
    logic     is_1op;
    logic     is_2op;
    logic     reg_dir;
    op1_e     fn1;
    op2_e     fn2;
    reg_idx_e src_reg;
    reg_idx_e dst_reg;

    assign is_1op     = (instr.cop[6:3] == COP_1OP) && (instr.cop[2:0] != 3'b111);
    assign is_2op     = (instr.cop[6:4] == COP_2OP);
    assign reg_dir    = (instr.mod == MOD_REG);
    assign fn1        = op1_e'(instr.cop[2:0]);
    assign fn2        = op2_e'(instr.cop[2:0]);
    assign exec_state = is_1op ? S_EXEC_1OP : S_EXEC_2OP;
    assign src_reg    = dec_d ? instr.rm.rg : instr.rg;
    assign dst_reg    = dec_d ? instr.rg : instr.rm.rg;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= S_RESET;
            dec_src   <= S_RESET;
            dec_dst   <= S_RESET;
            dec_store <= S_RESET;
            dec_d     <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_DECODE) begin
                dec_src   <= dec_src_next;
                dec_dst   <= dec_dst_next;
                dec_store <= dec_store_next;
                dec_d     <= dec_d_next;
            end
        end
    end

    //////////////////////////////
    // decode of the continuations
    always_comb begin
        dec_d_next     = 1'b0;          // one-operand forms use rm as dst
        dec_src_next   = S_INC_CP;
        dec_dst_next   = S_INC_CP;
        dec_store_next = S_INC_CP;
        if (is_1op) begin
            dec_dst_next   = reg_dir ? S_LD_DST_REG : S_LD_DST_AM;
            dec_src_next   = dec_dst_next;
            dec_store_next = reg_dir ? S_STORE_REG : S_STORE_MEM;
        end else if (is_2op) begin
            dec_d_next   = instr.d;
            dec_dst_next = (reg_dir || instr.d) ? S_LD_DST_REG : S_LD_DST_AM;
            dec_src_next = (reg_dir || !instr.d) ? S_LD_SRC_REG : S_LD_SRC_AM;
            if (instr.cop[3])           // store bit, clear for CMP/TEST
                dec_store_next = (reg_dir || instr.d) ? S_STORE_REG : S_STORE_MEM;
        end
    end

    //////////////////////////////
    // sequencing and strobes
    always_comb begin
        state_next = S_RESET;
        bus_src    = BUS_ALU;
        t1_we      = 1'b0;
        t2_we      = 1'b0;
        t1_oe      = 1'b0;
        t2_oe      = 1'b0;
        am_we      = 1'b0;
        ri_we      = 1'b0;
        ind_we     = 1'b0;
        cp_inc     = 1'b0;
        fetch_addr = 1'b0;
        mem_rd     = 1'b0;
        mem_wr     = 1'b0;
        reg_addr   = RA;
        reg_we     = 1'b0;
        alu_op     = ALU_OR;
        alu_cin    = 1'b0;

        case (state)
            S_RESET: state_next = S_FETCH;
            S_FETCH: begin
                fetch_addr = 1'b1;                  // address from CP
                mem_rd     = 1'b1;
                state_next = S_FETCH_LD;
            end
            S_FETCH_LD: begin
                bus_src    = BUS_MEM;
                ri_we      = 1'b1;
                state_next = S_DECODE;
            end
            S_DECODE: begin
                if (!is_1op && !is_2op)
                    state_next = S_INC_CP;          // unknown cop, skip
                else if (reg_dir)
                    state_next = dec_src_next;
                else if (instr.rm.am.single)
                    state_next = S_ADDR_REG;
                else
                    state_next = S_ADDR_SUM_BASE;
            end
            S_ADDR_SUM_BASE: begin
                bus_src    = BUS_REG;
                reg_addr   = instr.rm.am.base_b ? BB : BA;
                t1_we      = 1'b1;
                state_next = S_ADDR_SUM_IDX;
            end
            S_ADDR_SUM_IDX: begin
                bus_src    = BUS_REG;
                reg_addr   = instr.rm.am.index_b ? XB : XA;
                t2_we      = 1'b1;
                state_next = S_ADDR_SUM_ADD;
            end
            S_ADDR_SUM_ADD: begin
                t1_oe      = 1'b1;
                t2_oe      = 1'b1;
                alu_op     = ALU_ADC;               // base + index
                t1_we      = !dec_d;                // address beside the mem operand
                t2_we      = dec_d;
                state_next = dec_src;
            end
            S_ADDR_REG: begin
                bus_src    = BUS_REG;
                reg_addr   = instr.rm.rg;           // XA..BB
                t1_we      = !dec_d;
                t2_we      = dec_d;
                state_next = dec_src;
            end
            S_LD_SRC_REG: begin
                bus_src    = BUS_REG;
                reg_addr   = src_reg;
                t2_we      = 1'b1;
                state_next = dec_dst;
            end
            S_LD_SRC_AM: begin
                t2_oe      = 1'b1;                  // pass T2 to AM
                am_we      = 1'b1;
                state_next = S_LD_SRC_RD;
            end
            S_LD_SRC_RD: begin
                mem_rd     = 1'b1;
                state_next = S_LD_SRC_CAP;
            end
            S_LD_SRC_CAP: begin
                bus_src    = BUS_MEM;
                t2_we      = 1'b1;
                state_next = dec_dst;
            end
            S_LD_DST_REG: begin
                bus_src    = BUS_REG;
                reg_addr   = dst_reg;
                t1_we      = 1'b1;
                state_next = exec_state;
            end
            S_LD_DST_AM: begin
                t1_oe      = 1'b1;                  // pass T1 to AM
                am_we      = 1'b1;
                state_next = S_LD_DST_RD;
            end
            S_LD_DST_RD: begin
                mem_rd     = 1'b1;
                state_next = S_LD_DST_CAP;
            end
            S_LD_DST_CAP: begin
                bus_src    = BUS_MEM;
                t1_we      = 1'b1;
                state_next = exec_state;
            end
            S_EXEC_1OP: begin
                t1_oe  = 1'b1;
                t1_we  = 1'b1;
                ind_we = 1'b1;
                case (fn1)
                    OP1_INC: begin
                        alu_op  = ALU_ADC;
                        alu_cin = 1'b1;
                    end
                    OP1_DEC: begin
                        alu_op  = ALU_SBB;
                        alu_cin = 1'b1;
                    end
                    OP1_NEG: alu_op = ALU_NEG_SBB;  // 0 - T1
                    OP1_NOT: alu_op = ALU_NOT;
                    OP1_SHL: alu_op = ALU_SHL;
                    OP1_SHR: alu_op = ALU_SHR;
                    OP1_SAR: alu_op = ALU_SAR;
                    default: ;
                endcase
                state_next = dec_store;
            end
            S_EXEC_2OP: begin
                t1_oe  = 1'b1;
                t2_oe  = 1'b1;
                t1_we  = 1'b1;
                ind_we = 1'b1;
                case (fn2)
                    OP2_ADD: alu_op = ALU_ADC;
                    OP2_ADC: begin
                        alu_op  = ALU_ADC;
                        alu_cin = flags.carry;
                    end
                    OP2_SUB: alu_op = ALU_SBB;
                    OP2_SBB: begin
                        alu_op  = ALU_SBB;
                        alu_cin = flags.carry;      // stored borrow
                    end
                    OP2_AND: alu_op = ALU_AND;
                    OP2_OR:  alu_op = ALU_OR;
                    OP2_XOR: alu_op = ALU_XOR;
                    OP2_MOV: begin
                        t1_oe  = 1'b0;              // 0 | T2
                        ind_we = 1'b0;              // flags untouched
                    end
                    default: ;
                endcase
                state_next = dec_store;
            end
            S_STORE_REG: begin
                t1_oe      = 1'b1;
                reg_addr   = dst_reg;
                reg_we     = 1'b1;
                state_next = S_INC_CP;
            end
            S_STORE_MEM: begin
                t1_oe      = 1'b1;
                mem_wr     = 1'b1;                  // address from AM
                state_next = S_INC_CP;
            end
            S_INC_CP: begin
                cp_inc     = 1'b1;
                state_next = S_FETCH;
            end
            default: state_next = S_RESET;
        endcase
    end

endmodule

/* hw/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width of the core
`define CPU_WORD_WIDTH 16

// general registers RA..BB
`define CPU_REG_COUNT  8
`define CPU_REG_IDX_W  3

`endif

/* hw/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       mem_rd,
    output logic                       mem_wr,
    output logic [`CPU_WORD_WIDTH-1:0] mem_addr,
    output logic [`CPU_WORD_WIDTH-1:0] mem_wdata,
    input  logic [`CPU_WORD_WIDTH-1:0] mem_rdata
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    bus_src_e                   bus_src;
    logic                       t1_we;
    logic                       t2_we;
    logic                       t1_oe;
    logic                       t2_oe;
    logic                       am_we;
    logic                       ri_we;
    logic                       ind_we;
    logic                       cp_inc;
    logic                       fetch_addr;
    reg_idx_e                   reg_addr;
    logic                       reg_we;
    logic [`CPU_WORD_WIDTH-1:0] reg_rdata;
    logic [`CPU_WORD_WIDTH-1:0] reg_wdata;
    alu_op_e                    alu_op;
    logic                       alu_cin;
    logic [`CPU_WORD_WIDTH-1:0] alu_a;
    logic [`CPU_WORD_WIDTH-1:0] alu_b;
    logic [`CPU_WORD_WIDTH-1:0] alu_result;
    flags_t                     alu_flags;
    instr_t                     instr;      // RI contents
    flags_t                     flags;      // IND contents

    // port names match the local nets
    control_fsm ctrl_i (.*);

    datapath dp_i (.*);

    reg_file regs_i (
        .clk   (clk),
        .rst   (rst),
        .addr  (reg_addr),
        .we    (reg_we),
        .wdata (reg_wdata),
        .rdata (reg_rdata)
    );

    alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .cin    (alu_cin),
        .op     (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

endmodule

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADC,     // a + b + cin
        ALU_SBB,     // a - b - cin
        ALU_NEG_SBB, // b - a - cin
        ALU_NOT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_SAR
    } alu_op_e;

    // who drives the internal bus
    typedef enum logic [1:0] {
        BUS_ALU,
        BUS_REG,
        BUS_MEM,
        BUS_CP
    } bus_src_e;

    typedef struct packed {
        logic carry;    // carry out or borrow
        logic zero;
        logic sign;
        logic overflow;
    } flags_t;

endpackage

/* hw/datapath.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath (
    input  logic                       clk,
    input  logic                       rst,
    input  ctrl_pkg::bus_src_e         bus_src,
    input  logic                       t1_we,
    input  logic                       t2_we,
    input  logic                       t1_oe,
    input  logic                       t2_oe,
    input  logic                       am_we,
    input  logic                       ri_we,
    input  logic                       ind_we,
    input  logic                       cp_inc,
    input  logic                       fetch_addr,
    input  logic [`CPU_WORD_WIDTH-1:0] reg_rdata,
    input  logic [`CPU_WORD_WIDTH-1:0] alu_result,
    input  ctrl_pkg::flags_t           alu_flags,
    input  logic [`CPU_WORD_WIDTH-1:0] mem_rdata,
    output logic [`CPU_WORD_WIDTH-1:0] alu_a,
    output logic [`CPU_WORD_WIDTH-1:0] alu_b,
    output isa_pkg::instr_t            instr,
    output ctrl_pkg::flags_t           flags,
    output logic [`CPU_WORD_WIDTH-1:0] reg_wdata,
    output logic [`CPU_WORD_WIDTH-1:0] mem_addr,
    output logic [`CPU_WORD_WIDTH-1:0] mem_wdata
);
    import ctrl_pkg::*;

    logic [`CPU_WORD_WIDTH-1:0] bus;
    logic [`CPU_WORD_WIDTH-1:0] t1;         // destination operand and result
    logic [`CPU_WORD_WIDTH-1:0] t2;         // source operand
    logic [`CPU_WORD_WIDTH-1:0] am;         // memory address
    logic [`CPU_WORD_WIDTH-1:0] ri;         // instruction word
    logic [`CPU_WORD_WIDTH-1:0] cp;         // program counter
    flags_t                     ind;

    //////////////////////////////
    // internal bus
    always_comb begin
        case (bus_src)
            BUS_ALU: bus = alu_result;
            BUS_REG: bus = reg_rdata;
            BUS_MEM: bus = mem_rdata;
            default: bus = cp;
        endcase
    end

    always_ff @(posedge clk) begin
        if (t1_we) t1 <= bus;
        if (t2_we) t2 <= bus;
        if (am_we) am <= bus;
        if (ri_we) ri <= bus;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cp  <= '0;
            ind <= '0;
        end else begin
            if (cp_inc) cp <= cp + 1'b1;
            if (ind_we) ind <= alu_flags;   // flags of the last executed op
        end
    end

    //////////////////////////////
    // outputs
    assign alu_a     = t1_oe ? t1 : '0;
    assign alu_b     = t2_oe ? t2 : '0;
    assign instr     = ri;
    assign flags     = ind;
    assign reg_wdata = bus;
    assign mem_wdata = bus;
    assign mem_addr  = fetch_addr ? cp : am;

endmodule

/* hw/isa_pkg.sv */
`include "cpu_config.svh"

package isa_pkg;

    // register index as encoded in rg and rm
    typedef enum logic [`CPU_REG_IDX_W-1:0] {
        RA, RB, RC, RD,
        XA, XB, BA, BB
    } reg_idx_e;

    // rm seen as an address mode when mod is not 11
    typedef struct packed {
        logic single;   // one index register, no base
        logic base_b;   // base is BB instead of BA
        logic index_b;  // index is XB instead of XA
    } addr_mode_t;

    typedef union packed {
        reg_idx_e   rg; // register view, mod 11 and single-register mode
        addr_mode_t am; // addressing view
    } rm_field_u;

    typedef struct packed {
        logic [6:0] cop;
        logic       d;  // 1 when rg is the destination
        logic [1:0] mod;
        reg_idx_e   rg;
        rm_field_u  rm;
    } instr_t;

    typedef enum logic [2:0] {
        OP1_INC, OP1_DEC, OP1_NEG, OP1_NOT,
        OP1_SHL, OP1_SHR, OP1_SAR
    } op1_e;

    typedef enum logic [2:0] {
        OP2_ADD, OP2_ADC, OP2_SUB, OP2_SBB,
        OP2_AND, OP2_OR, OP2_XOR, OP2_MOV
    } op2_e;

    localparam logic [3:0] COP_1OP = 4'b0001; // cop[6:3] of one-operand group
    localparam logic [2:0] COP_2OP = 3'b010;  // cop[6:4] of two-operand group
    localparam logic [1:0] MOD_REG = 2'b11;   // register-direct operand

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst,
    input  isa_pkg::reg_idx_e          addr,   // shared by read and write
    input  logic                       we,
    input  logic [`CPU_WORD_WIDTH-1:0] wdata,
    output logic [`CPU_WORD_WIDTH-1:0] rdata
);

    logic [`CPU_WORD_WIDTH-1:0] regs [`CPU_REG_COUNT];

    assign rdata = regs[addr];                  // asynchronous read

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[addr] <= wdata;
        end
    end

endmodule

/* tests/cpu_cases.txt */
// word 0 is the case count; per case: load count, load pairs (address value),
// expected write count, expected write pairs (address value) in order; all hex
0004
// case 1: INC DEC NEG NOT SHL SHR SAR on [XA], XA stepped by register-direct INC
0016
0000 0040 0001 5f24 0002 1004 0003 10c4 0004 1204 0005 10c4 0006 1404 0007 10c4
0008 1604 0009 10c4 000a 1804 000b 10c4 000c 1a04 000d 10c4 000e 1c04
0040 7fff 0041 0000 0042 0005 0043 1234 0044 8421 0045 8421 0046 8421
0007
0040 8000 0041 ffff 0042 fffb 0043 edcb 0044 0842 0045 4210 0046 c210
// case 2: MOV into registers, ADD SUB AND OR XOR into memory, ADD/ADC and SUB/SBB
0024
0000 0040 0001 5f24 0002 5f04 0003 10c4 0004 5004 0005 10c4 0006 5404 0007 10c4
0008 5804 0009 10c4 000a 5a04 000b 10c4 000c 5c04 000d 10c4 000e 5f2c 000f 10c4
0010 5f0c 0011 10c4 0012 500c 0013 5205 0014 10c4 0015 10c5 0016 540c 0017 5605
0040 00f0 0041 1234 0042 1234 0043 5a5a 0044 5a5a 0045 5a5a 0046 0050 0047 9000
0048 8001 0049 1000 0050 0002 0051 0500
0009
0041 1324 0042 1144 0043 0050 0044 5afa 0045 5aaa 0048 1001 0050 00f3 0049 8000
0051 040f
// case 3: ADD RA into [BA+XA] [BA+XB] [BB+XA] [BB+XB]
0015
0000 0040 0001 5f24 0002 5f34 0003 10c4 0004 5f3c 0005 10c4 0006 5f2c 0007 10c4
0008 5f04 0009 5000 000a 5001 000b 5002 000c 5003
0040 0080 0041 00a0 0042 0010 0043 0101 00c3 1000 0090 2000 00e3 3000 00b0 4000
0004
00c3 1101 0090 2101 00e3 3101 00b0 4101
// case 4: register-direct ADD SHL SUB, CMP without store, MOV exposes RC and RB
000c
0000 0040 0001 5f24 0002 5f04 0003 5f0c 0004 50c1 0005 18c1 0006 55d1 0007 4404
0008 5e14 0009 10c4 000a 5e0c
0040 0003
0002
0040 fff4 0041 000c

/* tests/tb_cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu_core;

    localparam int W                = `CPU_WORD_WIDTH;
    localparam int HALF_PERIOD      = 20;       // 40 ns clock
    localparam int DRIVE_DELAY      = 2;        // inputs change after the rising edge
    localparam int RESET_CYCLES     = 3;
    localparam int CYCLES_PER_WRITE = 200;
    localparam int CASE_WORDS       = 512;

    logic         clk;
    logic         rst;
    logic         mem_rd;
    logic         mem_wr;
    logic [W-1:0] mem_addr;
    logic [W-1:0] mem_wdata;
    logic [W-1:0] mem_rdata;
    logic         wr_seen;
    logic [W-1:0] wr_addr;
    logic [W-1:0] wr_data;

    logic [W-1:0] case_words [CASE_WORDS];      // whole case file
    int           rd_ptr;                       // next word to take
    int           limit_cycles = 0;             // watchdog budget, set after the scan

    cpu_core dut_i (
        .clk       (clk),
        .rst       (rst),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    tb_memory #(.DEPTH(256)) mem_i (
        .clk     (clk),
        .rd      (mem_rd),
        .wr      (mem_wr),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata),
        .wr_seen (wr_seen),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    //////////////////////////////
    // helpers
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic take_word(output logic [W-1:0] w);
        w = case_words[rd_ptr];
        if ($isunknown(w))
            abort_run($sformatf("case file is unreadable or ends early at word %0d", rd_ptr));
        rd_ptr++;
    endtask

    // walks the file once to size the watchdog
    function automatic int count_expected_writes(input int n_cases);
        int p;
        int total;
        p     = 1;
        total = 0;
        for (int c = 0; c < n_cases; c++) begin
            p     = p + 1 + 2 * case_words[p];  // skip the load pairs
            total = total + case_words[p];
            p     = p + 1 + 2 * case_words[p];  // skip the write pairs
        end
        return total;
    endfunction

    task automatic wait_for_write();
        @(negedge clk);                         // memory outputs settled here
        while (wr_seen !== 1'b1) @(negedge clk);
    endtask

    //////////////////////////////
    // case sequence
    initial begin : run_cases
        logic [W-1:0] n_cases;
        logic [W-1:0] n_load;
        logic [W-1:0] n_writes;
        logic [W-1:0] load_addr;
        logic [W-1:0] load_data;
        logic [W-1:0] exp_addr;
        logic [W-1:0] exp_data;
        rst    = 1'b0;                          // core held in reset from time 0
        rd_ptr = 0;
        $readmemh("tests/cpu_cases.txt", case_words);
        take_word(n_cases);
        if (n_cases == 0) abort_run("the case file holds no cases");
        limit_cycles = count_expected_writes(n_cases) * CYCLES_PER_WRITE + n_cases * 10;

        for (int c = 1; c <= n_cases; c++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            rst = 1'b0;
            mem_i.clear_words();
            take_word(n_load);
            for (int i = 0; i < n_load; i++) begin
                take_word(load_addr);
                take_word(load_data);
                mem_i.load_word(load_addr, load_data);
            end
            take_word(n_writes);
            repeat (RESET_CYCLES) @(posedge clk);
            #(DRIVE_DELAY);
            rst = 1'b1;                         // first fetch from word 0

            for (int i = 1; i <= n_writes; i++) begin
                take_word(exp_addr);
                take_word(exp_data);
                wait_for_write();
                assert (wr_addr == exp_addr) else
                    abort_run($sformatf("error at %0t ns: case %0d write %0d address %h, expected %h",
                                        $time, c, i, wr_addr, exp_addr));
                assert (wr_data == exp_data) else
                    abort_run($sformatf("error at %0t ns: case %0d write %0d data %h, expected %h",
                                        $time, c, i, wr_data, exp_data));
            end
            $display("case %0d: %0d writes matched", c, n_writes);
        end

        $display("Everything OK");
        $finish;
    end

    //////////////////////////////
    // watchdog
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run($sformatf("timeout: the core stopped writing within %0d cycles", limit_cycles));
    end

endmodule

/* tests/tb_memory.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_memory #(
    parameter int DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       rd,        // read strobe, data in the next cycle
    input  logic                       wr,        // write strobe, done at this edge
    input  logic [`CPU_WORD_WIDTH-1:0] addr,
    input  logic [`CPU_WORD_WIDTH-1:0] wdata,
    output logic [`CPU_WORD_WIDTH-1:0] rdata,
    output logic                       wr_seen,   // one cycle after each write
    output logic [`CPU_WORD_WIDTH-1:0] wr_addr,   // full address of the last write
    output logic [`CPU_WORD_WIDTH-1:0] wr_data
);

    localparam int AW = $clog2(DEPTH);

    logic [`CPU_WORD_WIDTH-1:0] words [DEPTH];

    initial begin
        rdata   = '0;
        wr_seen = 1'b0;
        wr_addr = '0;
        wr_data = '0;
    end

    always @(posedge clk) begin
        wr_seen <= wr;
        if (rd) rdata <= words[addr[AW-1:0]];       // upper address bits alias
        if (wr) begin
            words[addr[AW-1:0]] = wdata;
            wr_addr <= addr;                         // handed to the checker
            wr_data <= wdata;
        end
    end

    task automatic clear_words();
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = '0;                           // zero decodes as a no-op
        end
    endtask

    task automatic load_word(input logic [`CPU_WORD_WIDTH-1:0] a,
                             input logic [`CPU_WORD_WIDTH-1:0] v);
        words[a[AW-1:0]] = v;
    endtask

endmodule
